// ==== bench/sd_card_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module sd_card_model #(
  parameter int          block_bytes = 16,
  parameter logic [31:0] ocr         = 32'hC0FF_8000
) (
  input  logic                     clock,
  input  logic                     cs_n,
  input  logic                     mosi,
  output logic                     miso,
  input  logic [block_bytes*8-1:0] block,
  input  logic                     corrupt_crc,
  input  logic                     silent,
  output logic [47:0]              frame,
  output logic                     frame_seen,
  output logic                     crc7_ok
);

  // CRC7 over start bit through argument, x^7 + x^3 + 1
  function automatic logic [6:0] crc7_of(input logic [39:0] bits);
    logic [6:0] crc;
    crc = 7'd0;
    for (int i = 39; i >= 0; i--) begin
      crc = (crc[6] ^ bits[i]) ? ({crc[5:0], 1'b0} ^ 7'h09) : {crc[5:0], 1'b0};
    end
    return crc;
  endfunction

  // Data block CRC16-CCITT, zero initial value
  function automatic logic [15:0] crc16_of(input logic [block_bytes*8-1:0] bits);
    logic [15:0] crc;
    crc = 16'd0;
    for (int i = block_bytes * 8 - 1; i >= 0; i--) begin
      crc = (crc[15] ^ bits[i]) ? ({crc[14:0], 1'b0} ^ 16'h1021) : {crc[14:0], 1'b0};
    end
    return crc;
  endfunction

  // MSB first, one bit per clock, changed just after the rising edge
  task automatic send_bits(input logic [31:0] value, input int count);
    for (int i = count - 1; i >= 0; i--) begin
      @(posedge clock);
      #1;
      frame_seen = 1'b0;
      miso = value[i];
    end
  endtask

  task automatic answer();
    // Fixed four clock gap before the response
    send_bits(32'hF, 4);
    case (frame[45:40])
      6'd0: send_bits(32'h01, 8);
      6'd8: begin
        send_bits(32'h00, 8);
        send_bits(frame[39:8], 32);
      end
      6'd58: begin
        send_bits(32'h00, 8);
        send_bits(ocr, 32);
      end
      6'd17: begin
        // R1, one idle byte, then the 0xFE token
        send_bits(32'h00, 8);
        send_bits(32'hFFFE, 16);
        for (int i = block_bytes - 1; i >= 0; i--) begin
          send_bits({24'h0, block[i*8 +: 8]}, 8);
        end
        send_bits({16'h0, crc16_of(block) ^ {15'h0, corrupt_crc}}, 16);
      end
      default: ;
    endcase
    @(posedge clock);
    #1;
    miso = 1'b1;
  endtask

  initial begin
    miso = 1'b1;
    frame = '0;
    frame_seen = 1'b0;
    crc7_ok = 1'b0;
    forever begin
      @(posedge clock);
      #1;
      frame_seen = 1'b0;
      // Low mosi under chip select is the start bit
      if (!cs_n && !mosi) begin
        frame = '0;
        for (int i = 1; i < 48; i++) begin
          @(posedge clock);
          #1;
          frame = {frame[46:0], mosi};
        end
        crc7_ok = (crc7_of(frame[47:8]) == frame[7:1]);
        frame_seen = 1'b1;
        if (!silent) begin
          answer();
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/sd_spi_host_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module sd_spi_host_tb;
  import sd_pkg::*;

  localparam int          block_bytes = 16;
  localparam logic [31:0] card_ocr    = 32'hC0FF_8000;

  logic                     clock = 1'b0;
  logic                     reset = 1'b1;
  logic                     cmd_start = 1'b0;
  sd_command                cmd_opcode = go_idle_state;
  logic [31:0]              cmd_argument = 32'h0;
  logic                     busy;
  logic                     done;
  logic [7:0]               r1_status;
  logic [31:0]              response_payload;
  logic [block_bytes*8-1:0] block_data;
  logic                     crc_ok;
  logic                     timed_out;
  logic                     cs_n;
  logic                     mosi;
  logic                     miso;
  logic [block_bytes*8-1:0] card_block = '0;
  logic                     corrupt_crc = 1'b0;
  logic                     card_silent = 1'b0;
  logic [47:0]              card_frame;
  logic                     frame_seen;
  logic                     crc7_ok;
  logic [31:0]              lfsr_state = 32'h0669_ef66;

  always #5 clock = ~clock;

  sd_spi_host #(.block_bytes(block_bytes), .response_timeout(64)) dut (.*);

  sd_card_model #(.block_bytes(block_bytes), .ocr(card_ocr)) card (
    .clock      (clock),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .miso       (miso),
    .block      (card_block),
    .corrupt_crc(corrupt_crc),
    .silent     (card_silent),
    .frame      (card_frame),
    .frame_seen (frame_seen),
    .crc7_ok    (crc7_ok)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic expect_value(input string name, input logic [127:0] actual,
                              input logic [127:0] expected);
    assert (actual == expected) else
      abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected));
  endtask

  // Galois LFSR, x^32 + x^30 + x^26 + x^25 + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'hA300_0000) : (state >> 1);
  endfunction

  task automatic take_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic fill_block();
    logic [31:0] bits;
    for (int i = block_bytes - 1; i >= 0; i--) begin
      take_bits(8, bits);
      card_block[i*8 +: 8] = bits[7:0];
    end
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic issue_command(input sd_command opcode, input logic [31:0] argument);
    int cycles;
    cycles = 0;
    while (busy) begin
      assert (cycles < 1000) else abort_run("DUT stayed busy before a new request");
      next_cycle();
      cycles++;
    end
    cmd_opcode = opcode;
    cmd_argument = argument;
    cmd_start = 1'b1;
    next_cycle();
    cmd_start = 1'b0;
  endtask

  task automatic wait_for_done();
    int cycles;
    cycles = 0;
    while (!done) begin
      assert (cycles < 1000) else abort_run("No done from the DUT within 1000 cycles");
      next_cycle();
      cycles++;
    end
  endtask

  // Every frame the card decodes needs a valid CRC7 and end bit
  always @(negedge clock) begin
    if (frame_seen) begin
      assert (crc7_ok && card_frame[0]) else
        abort_run("Card received a frame with a bad CRC7 or end bit");
    end
  end

  initial begin
    logic [31:0] argument;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    expect_value("cs_n", 128'(cs_n), 128'h1);
    expect_value("mosi", 128'(mosi), 128'h1);
    expect_value("busy", 128'(busy), 128'h0);
    expect_value("done", 128'(done), 128'h0);

    issue_command(go_idle_state, 32'h0);
    wait_for_done();
    expect_value("card_frame[7:0]", 128'(card_frame[7:0]), 128'h95);
    expect_value("r1_status", 128'(r1_status), 128'h01);
    expect_value("timed_out", 128'(timed_out), 128'h0);
    expect_value("crc_ok", 128'(crc_ok), 128'h1);
    expect_value("cs_n", 128'(cs_n), 128'h1);

    take_bits(32, argument);
    issue_command(send_if_cond, argument);
    wait_for_done();
    expect_value("r1_status", 128'(r1_status), 128'h00);
    expect_value("response_payload", 128'(response_payload), 128'(argument));
    issue_command(read_ocr, 32'h0);
    wait_for_done();
    expect_value("r1_status", 128'(r1_status), 128'h00);
    expect_value("response_payload", 128'(response_payload), 128'(card_ocr));

    fill_block();
    issue_command(read_single_block, 32'h0);
    wait_for_done();
    expect_value("block_data", 128'(block_data), 128'(card_block));
    expect_value("crc_ok", 128'(crc_ok), 128'h1);
    expect_value("timed_out", 128'(timed_out), 128'h0);

    // One flipped CRC16 bit
    fill_block();
    corrupt_crc = 1'b1;
    issue_command(read_single_block, 32'h0);
    wait_for_done();
    expect_value("block_data", 128'(block_data), 128'(card_block));
    expect_value("crc_ok", 128'(crc_ok), 128'h0);

    // Silent card, with a second request strobed while busy
    card_silent = 1'b1;
    issue_command(go_idle_state, 32'h0);
    repeat (3) next_cycle();
    expect_value("busy", 128'(busy), 128'h1);
    cmd_start = 1'b1;
    next_cycle();
    cmd_start = 1'b0;
    wait_for_done();
    expect_value("timed_out", 128'(timed_out), 128'h1);
    for (int i = 0; i < 200; i++) begin
      next_cycle();
      assert (!done) else abort_run("A second done followed a request made while busy");
    end
    expect_value("busy", 128'(busy), 128'h0);

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the SD SPI host testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sd_spi_host.f \
  --top-module sd_spi_host_tb -Mdir obj_dir -o sd_spi_host_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sd_spi_host_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

printf '%s\n' "$output" | grep -qx "Testbench passed"
exit $?

// ==== sd_spi_host.f ====
verilog/sd_pkg.sv
verilog/sd_transmitter.sv
verilog/sd_receiver.sv
verilog/sd_command_engine.sv
verilog/sd_spi_host.sv
bench/sd_card_model.sv
bench/sd_spi_host_tb.sv

// ==== verilog/sd_command_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module sd_command_engine #(
  parameter int block_bytes      = 512,
  parameter int response_timeout = 64
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     cmd_start,
  input  sd_pkg::sd_command        cmd_opcode,
  input  logic [31:0]              cmd_argument,
  output logic                     busy,
  output logic                     done,
  output logic [7:0]               r1_status,
  output logic [31:0]              response_payload,
  output logic [block_bytes*8-1:0] block_data,
  output logic                     crc_ok,
  output logic                     timed_out,
  output logic                     cs_n,
  output logic                     tx_start,
  output sd_pkg::sd_command        tx_opcode,
  output logic [31:0]              tx_argument,
  input  logic                     tx_done,
  output logic                     rx_arm,
  output logic                     rx_abort,
  output sd_pkg::sd_response_kind  rx_kind,
  input  logic [block_bytes*8-1:0] rx_data,
  input  logic                     rx_crc_ok,
  input  logic                     rx_done
);
  import sd_pkg::*;

  localparam int data_bits = block_bytes * 8;
  localparam int timeout_bits = $clog2(response_timeout + data_bits + 18);

  typedef enum logic [2:0] {
    idle,
    send,
    wait_response,
    wait_block,
    finish
  } engine_state_t;

  engine_state_t           state;
  sd_response_kind         first_kind;
  sd_response_kind         wait_kind;
  logic [timeout_bits-1:0] wait_count;
  logic [timeout_bits-1:0] wait_limit;
  logic                    waiting;
  logic                    block_follows;
  logic                    expired;
  logic                    capture_response;
  logic                    capture_block;

  // Response shape of each opcode; a read opens with R1
  always_comb begin
    case (tx_opcode)
      send_if_cond, read_ocr: first_kind = response_r3_r7;
      default:                first_kind = response_r1;
    endcase
  end

  assign wait_kind = (state == wait_block) ? response_data_block : first_kind;

  // The receiver has no start indication, so the limit covers the allowed
  // start latency plus the response length. A start bit sampled on the last
  // allowed clock gives rx_done exactly when wait_count hits the limit
  always_comb begin
    case (wait_kind)
      response_r1:    wait_limit = timeout_bits'(response_timeout + 7);
      response_r3_r7: wait_limit = timeout_bits'(response_timeout + 39);
      default:        wait_limit = timeout_bits'(response_timeout + data_bits + 16);
    endcase
  end

  assign waiting = (state == wait_response) || (state == wait_block);
  assign expired = waiting && !rx_done && (wait_count == wait_limit);
  assign block_follows = (tx_opcode == read_single_block) && (rx_data[7:0] == 8'h00);

  assign capture_response = (state == wait_response) && rx_done && !block_follows;
  assign capture_block = (state == wait_block) && rx_done;

  // Arm for the first response when the frame is out, then again for a block
  assign rx_arm = (state == send && tx_done) ||
                  (state == wait_response && rx_done && block_follows);
  assign rx_kind = (state == wait_response) ? response_data_block : first_kind;
  assign rx_abort = expired;

  assign busy = (state != idle);
  assign done = (state == finish);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
      tx_start <= 1'b0;
      cs_n <= 1'b1;
      wait_count <= '0;
    end else begin
      tx_start <= 1'b0;
      case (state)
        idle: begin
          if (cmd_start) begin
            tx_start <= 1'b1;
            cs_n <= 1'b0;
            state <= send;
          end
        end
        send: begin
          if (tx_done) begin
            wait_count <= '0;
            state <= wait_response;
          end
        end
        wait_response, wait_block: begin
          wait_count <= wait_count + 1'b1;
          if (rx_arm) begin
            // Fresh timeout for the data token
            wait_count <= '0;
            state <= wait_block;
          end else if (rx_done || expired) begin
            cs_n <= 1'b1;
            state <= finish;
          end
        end
        finish: state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // Request fields, held for the transmitter and opcode decode
  always_ff @(posedge clock) begin
    if (state == idle && cmd_start) begin
      tx_opcode <= cmd_opcode;
      tx_argument <= cmd_argument;
    end
  end

  // Results change only on the edge that raises done
  always_ff @(posedge clock) begin
    if (capture_response) begin
      if (first_kind == response_r3_r7) begin
        r1_status <= rx_data[39:32];
        response_payload <= rx_data[31:0];
      end else begin
        r1_status <= rx_data[7:0];
        response_payload <= 32'h0;
      end
      crc_ok <= rx_crc_ok;
      timed_out <= 1'b0;
    end else if (capture_block) begin
      r1_status <= 8'h00;
      response_payload <= 32'h0;
      block_data <= rx_data;
      crc_ok <= rx_crc_ok;
      timed_out <= 1'b0;
    end else if (expired) begin
      // Idle line reads as all ones; a missing block follows a zero R1
      r1_status <= (state == wait_block) ? 8'h00 : 8'hFF;
      response_payload <= 32'h0;
      crc_ok <= 1'b0;
      timed_out <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sd_pkg.sv ====
`default_nettype none

package sd_pkg;

  // Start bit through end bit of one command on mosi
  localparam int command_frame_bits = 48;

  // Response shapes the receiver can be armed for
  typedef enum logic [1:0] {
    response_r1,
    response_r3_r7,
    response_data_block
  } sd_response_kind;

  // Supported commands, each valued by its SD command index
  typedef enum logic [5:0] {
    go_idle_state     = 6'd0,
    send_if_cond      = 6'd8,
    read_single_block = 6'd17,
    read_ocr          = 6'd58
  } sd_command;

endpackage

`default_nettype wire

// ==== verilog/sd_receiver.sv ====
`timescale 1ns/100ps
`default_nettype none

module sd_receiver #(
  parameter int block_bytes = 512
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    rx_arm,
  input  logic                    rx_abort,
  input  sd_pkg::sd_response_kind rx_kind,
  input  logic                    miso,
  output logic [block_bytes*8-1:0] rx_data,
  output logic                    rx_crc_ok,
  output logic                    rx_done
);
  import sd_pkg::*;

  localparam int data_bits = block_bytes * 8;
  // Token bit, payload and CRC16
  localparam int block_length = data_bits + 17;
  localparam int count_bits = $clog2(block_length + 1);

  typedef enum logic [1:0] {
    idle,
    armed,
    receive
  } rx_state_t;

  rx_state_t             state;
  sd_response_kind       kind;
  logic [count_bits-1:0] bits_left;
  logic [count_bits-1:0] response_length;
  logic [15:0]           crc16;
  logic                  crc_feedback;
  logic                  start;
  logic                  in_receive;
  logic                  sampling;
  logic                  shift_enable;

  // Length in bits, start bit included
  always_comb begin
    case (kind)
      response_r1:    response_length = count_bits'(8);
      response_r3_r7: response_length = count_bits'(40);
      default:        response_length = count_bits'(block_length);
    endcase
  end

  // Arm and abort take over whatever the line is doing
  assign start = (state == armed) && !miso && !rx_arm && !rx_abort;
  assign in_receive = (state == receive) && !rx_arm && !rx_abort;
  assign sampling = start || in_receive;

  // The trailing CRC16 never enters the data register
  assign shift_enable = start ||
                        (in_receive && !(kind == response_data_block && bits_left <= 16));

  assign rx_crc_ok = (kind != response_data_block) || (crc16 == 16'h0000);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
      kind <= response_r1;
      bits_left <= '0;
      rx_done <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      if (rx_arm) begin
        kind <= rx_kind;
        state <= armed;
      end else if (rx_abort) begin
        state <= idle;
      end else begin
        case (state)
          idle: state <= idle;
          armed: begin
            if (start) begin
              bits_left <= response_length - 1'b1;
              state <= receive;
            end
          end
          receive: begin
            bits_left <= bits_left - 1'b1;
            if (bits_left == count_bits'(1)) begin
              rx_done <= 1'b1;
              state <= idle;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (shift_enable) begin
      rx_data <= {rx_data[data_bits-2:0], miso};
    end
  end

  // CRC16-CCITT, x^16 + x^12 + x^5 + 1
  // A zero start bit leaves a cleared LFSR unchanged
  assign crc_feedback = crc16[15] ^ miso;

  always_ff @(posedge clock) begin
    if (rx_arm) begin
      crc16 <= 16'h0000;
    end else if (sampling) begin
      crc16[0] <= crc_feedback;
      crc16[4:1] <= crc16[3:0];
      crc16[5] <= crc16[4] ^ crc_feedback;
      crc16[11:6] <= crc16[10:5];
      crc16[12] <= crc16[11] ^ crc_feedback;
      crc16[15:13] <= crc16[14:12];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sd_spi_host.sv ====
`timescale 1ns/100ps
`default_nettype none

module sd_spi_host #(
  parameter int block_bytes      = 512,
  parameter int response_timeout = 64
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     cmd_start,
  input  sd_pkg::sd_command        cmd_opcode,
  input  logic [31:0]              cmd_argument,
  output logic                     busy,
  output logic                     done,
  output logic [7:0]               r1_status,
  output logic [31:0]              response_payload,
  output logic [block_bytes*8-1:0] block_data,
  output logic                     crc_ok,
  output logic                     timed_out,
  output logic                     cs_n,
  output logic                     mosi,
  input  logic                     miso
);
  import sd_pkg::*;

  // Engine to transmitter
  logic        tx_start;
  sd_command   tx_opcode;
  logic [31:0] tx_argument;
  logic        tx_done;

  // Engine to receiver
  logic                     rx_arm;
  logic                     rx_abort;
  sd_response_kind          rx_kind;
  logic [block_bytes*8-1:0] rx_data;
  logic                     rx_crc_ok;
  logic                     rx_done;

  sd_command_engine #(
    .block_bytes     (block_bytes),
    .response_timeout(response_timeout)
  ) engine (
    .clock           (clock),
    .reset           (reset),
    .cmd_start       (cmd_start),
    .cmd_opcode      (cmd_opcode),
    .cmd_argument    (cmd_argument),
    .busy            (busy),
    .done            (done),
    .r1_status       (r1_status),
    .response_payload(response_payload),
    .block_data      (block_data),
    .crc_ok          (crc_ok),
    .timed_out       (timed_out),
    .cs_n            (cs_n),
    .tx_start        (tx_start),
    .tx_opcode       (tx_opcode),
    .tx_argument     (tx_argument),
    .tx_done         (tx_done),
    .rx_arm          (rx_arm),
    .rx_abort        (rx_abort),
    .rx_kind         (rx_kind),
    .rx_data         (rx_data),
    .rx_crc_ok       (rx_crc_ok),
    .rx_done         (rx_done)
  );

  sd_transmitter transmitter (
    .clock      (clock),
    .reset      (reset),
    .tx_start   (tx_start),
    .tx_opcode  (tx_opcode),
    .tx_argument(tx_argument),
    .mosi       (mosi),
    .tx_done    (tx_done)
  );

  sd_receiver #(
    .block_bytes(block_bytes)
  ) receiver (
    .clock    (clock),
    .reset    (reset),
    .rx_arm   (rx_arm),
    .rx_abort (rx_abort),
    .rx_kind  (rx_kind),
    .miso     (miso),
    .rx_data  (rx_data),
    .rx_crc_ok(rx_crc_ok),
    .rx_done  (rx_done)
  );

endmodule

`default_nettype wire

// ==== verilog/sd_transmitter.sv ====
`timescale 1ns/100ps
`default_nettype none

module sd_transmitter (
  input  logic              clock,
  input  logic              reset,
  input  logic              tx_start,
  input  sd_pkg::sd_command tx_opcode,
  input  logic [31:0]       tx_argument,
  output logic              mosi,
  output logic              tx_done
);
  import sd_pkg::*;

  localparam int count_bits = $clog2(command_frame_bits);

  typedef enum logic {
    idle,
    shift
  } tx_state_t;

  tx_state_t               state;
  logic [command_frame_bits-1:0] frame;
  logic [count_bits-1:0]   bit_count;
  logic [39:0]             frame_head;
  logic [6:0]              crc7;

  // Serial CRC7, polynomial x^7 + x^3 + 1, MSB first
  function automatic logic [6:0] compute_crc7(input logic [39:0] bits);
    logic [6:0] crc;
    logic       feedback;
    crc = 7'd0;
    for (int i = 39; i >= 0; i--) begin
      feedback = crc[6] ^ bits[i];
      crc = {crc[5:0], 1'b0};
      if (feedback) begin
        crc = crc ^ 7'h09;
      end
    end
    return crc;
  endfunction

  // Start bit, transmission bit, index and argument
  assign frame_head = {2'b01, tx_opcode, tx_argument};
  assign crc7 = compute_crc7(frame_head);

  // Line rests high between frames
  assign mosi = (state == shift) ? frame[command_frame_bits-1] : 1'b1;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
      bit_count <= '0;
      tx_done <= 1'b0;
    end else begin
      tx_done <= 1'b0;
      case (state)
        idle: begin
          if (tx_start) begin
            bit_count <= count_bits'(command_frame_bits - 1);
            state <= shift;
          end
        end
        shift: begin
          if (bit_count == '0) begin
            // Last bit is on the pin this cycle
            tx_done <= 1'b1;
            state <= idle;
          end else begin
            bit_count <= bit_count - 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == idle && tx_start) begin
      frame <= {frame_head, crc7, 1'b1};
    end else if (state == shift) begin
      frame <= {frame[command_frame_bits-2:0], 1'b1};
    end
  end

endmodule

`default_nettype wire
